//--- hsid_pkg.sv
`default_nettype none

package hsid_pkg;

  // Sample and word sizing
  localparam int data_width = 16;              // One band sample, one lane input
  localparam int word_width = 2 * data_width;  // Two samples per element word

  // Lane arithmetic sizing
  localparam int data_width_mul = 2 * data_width;  // Square of a 17-bit signed difference fits here
  localparam int data_width_acc = 48;              // Lane accumulator, headroom for 255 squares

  // Band count limits
  localparam int hsi_bands_max  = 255;                      // Largest band count
  localparam int hsi_bands_addr = $clog2(hsi_bands_max + 1);  // 8 bits

  // Library limits
  localparam int hsi_library_size = 4095;                          // Largest library
  localparam int hsi_library_addr = $clog2(hsi_library_size + 1);  // 12 bits

  // Lane-sum stage, one carry bit above a lane accumulator
  localparam int sum_width = data_width_acc + 1;

endpackage

`default_nettype wire

//--- hsid_elem_if.sv
`default_nettype none

interface hsid_elem_if;
  import hsid_pkg::*;

  logic                        element_valid;  // Element counts only when high
  logic                        element_start;  // First element of a reference vector
  logic                        element_last;   // Final element of a reference vector
  logic [hsi_library_addr-1:0] vctr_ref;       // Reference index, held for the vector
  logic [word_width-1:0]       element_a;      // Pixel word, two bands
  logic [word_width-1:0]       element_b;      // Reference word, two bands

  // Stream driver side
  modport source (
    output element_valid,
    output element_start,
    output element_last,
    output vctr_ref,
    output element_a,
    output element_b
  );

  // Error unit side
  modport sink (
    input element_valid,
    input element_start,
    input element_last,
    input vctr_ref,
    input element_a,
    input element_b
  );

endinterface

`default_nettype wire

//--- hsid_acc_if.sv
`default_nettype none

interface hsid_acc_if;
  import hsid_pkg::*;

  logic                        acc_valid;  // One pulse per accepted element
  logic [data_width_acc-1:0]   acc_value;  // Running sum including this element
  logic                        acc_last;   // Sum is complete for the vector
  logic [hsi_library_addr-1:0] acc_ref;    // Reference the sum belongs to

  // Lane side
  modport source (
    output acc_valid,
    output acc_value,
    output acc_last,
    output acc_ref
  );

  // Error unit side
  modport sink (
    input acc_valid,
    input acc_value,
    input acc_last,
    input acc_ref
  );

endinterface

`default_nettype wire

//--- hsid_sq_df_acc.sv
`default_nettype none

module hsid_sq_df_acc (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  data_in_valid,   // Element strobe
  input  logic                                  initial_acc_en,  // Restart sum at this element
  input  logic                                  data_in_last,    // Closes the vector
  input  logic [hsid_pkg::data_width-1:0]       data_in_a,       // Pixel sample
  input  logic [hsid_pkg::data_width-1:0]       data_in_b,       // Reference sample
  input  logic [hsid_pkg::hsi_library_addr-1:0] data_in_ref,     // Reference index
  hsid_acc_if.source                            acc
);
  import hsid_pkg::*;

  // Difference stage
  logic                           diff_valid;
  logic                           diff_start;
  logic                           diff_last;
  logic [hsi_library_addr-1:0]    diff_ref;
  logic signed [data_width:0]     diff;       // One sign bit above the samples

  // Square stage
  logic                           sq_valid;
  logic                           sq_start;
  logic                           sq_last;
  logic [hsi_library_addr-1:0]    sq_ref;
  logic [data_width_mul-1:0]      sq;
  logic signed [2*data_width+1:0] sq_full;    // Full signed product, never negative

  // Vector tracking for the reference check
  logic                           vec_open;   // Inside a start..last span
  logic [hsi_library_addr-1:0]    vec_ref;    // Index seen on the previous element

  assign sq_full = diff * diff;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      diff_valid    <= 1'b0;
      diff_start    <= 1'b0;
      diff_last     <= 1'b0;
      diff_ref      <= '0;
      diff          <= '0;
      sq_valid      <= 1'b0;
      sq_start      <= 1'b0;
      sq_last       <= 1'b0;
      sq_ref        <= '0;
      sq            <= '0;
      acc.acc_valid <= 1'b0;
      acc.acc_last  <= 1'b0;
      acc.acc_ref   <= '0;
      acc.acc_value <= '0;
      vec_open      <= 1'b0;
      vec_ref       <= '0;
    end else begin
      diff_valid <= data_in_valid;                    // Flags only count with the strobe
      diff_start <= data_in_valid && initial_acc_en;
      diff_last  <= data_in_valid && data_in_last;
      if (data_in_valid) begin
        diff_ref <= data_in_ref;
        diff     <= $signed({1'b0, data_in_a}) - $signed({1'b0, data_in_b});  // a - b
        vec_open <= !data_in_last;                    // Last element closes the span
        vec_ref  <= data_in_ref;
      end

      sq_valid <= diff_valid;
      sq_start <= diff_start;
      sq_last  <= diff_last;
      if (diff_valid) begin
        sq_ref <= diff_ref;
        sq     <= sq_full[data_width_mul-1:0];      // Max 65535^2 fits in 32 bits
      end

      acc.acc_valid <= sq_valid;
      acc.acc_last  <= sq_last;
      if (sq_valid) begin
        acc.acc_ref <= sq_ref;
        if (sq_start) begin
          acc.acc_value <= data_width_acc'(sq);     // New vector, drop the old sum
        end else begin
          acc.acc_value <= acc.acc_value + data_width_acc'(sq);
        end
      end
    end
  end

  // Index must be held from start to last, across idle cycles too
  ref_held_a: assert property (@(posedge clk) disable iff (!rst_n)
    (data_in_valid && vec_open && !initial_acc_en) |-> (data_in_ref == vec_ref))
    else $error("hsid_sq_df_acc: reference index changed inside a vector");

endmodule

`default_nettype wire

//--- hsid_mse.sv
`default_nettype none

module hsid_mse (
  input  logic                                  clk,
  input  logic                                  rst_n,
  hsid_elem_if.sink                             elem,       // Element stream
  input  logic [hsid_pkg::hsi_bands_addr-1:0]   hsi_bands,  // Divisor, bands per vector
  output logic [hsid_pkg::word_width-1:0]       mse_value,  // Mean square error
  output logic [hsid_pkg::hsi_library_addr-1:0] mse_ref,    // Reference of that error
  output logic                                  mse_valid   // One pulse per vector
);
  import hsid_pkg::*;

  hsid_acc_if acc_1 ();  // Lower half lane result
  hsid_acc_if acc_2 ();  // Upper half lane result

  logic                        start_en;   // Start flag qualified by the strobe
  logic                        sum_en;     // Both lanes closed the same vector
  logic                        sum_valid;
  logic [sum_width-1:0]        sum_value;  // Lane-sum stage
  logic [hsi_library_addr-1:0] sum_ref;
  logic [sum_width-1:0]        quotient;

  assign start_en = elem.element_valid && elem.element_start;

  assign sum_en = acc_1.acc_valid && acc_2.acc_valid
               && acc_1.acc_last && acc_2.acc_last
               && (acc_1.acc_ref == acc_2.acc_ref);

  assign quotient = sum_value / sum_width'(hsi_bands);  // Floor division

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
      sum_value <= '0;
      sum_ref   <= '0;
      mse_valid <= 1'b0;
      mse_value <= '0;
      mse_ref   <= '0;
    end else begin
      sum_valid <= sum_en;
      if (sum_en) begin
        sum_value <= sum_width'(acc_1.acc_value) + sum_width'(acc_2.acc_value);  // Carry kept
        sum_ref   <= acc_1.acc_ref;
      end

      mse_valid <= sum_valid;  // Division result one cycle after the sum
      if (sum_valid) begin
        mse_value <= quotient[word_width-1:0];  // Truncated to the word
        mse_ref   <= sum_ref;
      end
    end
  end

  // Lower samples of each word
  hsid_sq_df_acc channel_1 (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_valid  (elem.element_valid),
    .initial_acc_en (start_en),
    .data_in_last   (elem.element_last),
    .data_in_a      (elem.element_a[data_width-1:0]),
    .data_in_b      (elem.element_b[data_width-1:0]),
    .data_in_ref    (elem.vctr_ref),
    .acc            (acc_1.source)
  );

  // Upper samples of each word
  hsid_sq_df_acc channel_2 (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_valid  (elem.element_valid),
    .initial_acc_en (start_en),
    .data_in_last   (elem.element_last),
    .data_in_a      (elem.element_a[word_width-1:data_width]),
    .data_in_b      (elem.element_b[word_width-1:data_width]),
    .data_in_ref    (elem.vctr_ref),
    .acc            (acc_2.source)
  );

  // Lanes run in lockstep, so a lone or mismatched result means lost data
  lanes_agree_a: assert property (@(posedge clk) disable iff (!rst_n)
    (acc_1.acc_valid || acc_2.acc_valid) |->
      (acc_1.acc_valid && acc_2.acc_valid
       && (acc_1.acc_last == acc_2.acc_last)
       && (acc_1.acc_ref == acc_2.acc_ref)))
    else $error("hsid_mse: lane results disagree");

  // Division at the end of the pipeline needs a nonzero band count
  bands_nonzero_a: assert property (@(posedge clk) disable iff (!rst_n)
    elem.element_valid |-> (hsi_bands != '0))
    else $error("hsid_mse: hsi_bands is zero while elements flow");

endmodule

`default_nettype wire

//--- hsid_min_search.sv
`default_nettype none

module hsid_min_search (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  mse_valid,   // Error strobe
  input  logic [hsid_pkg::word_width-1:0]       mse_value,
  input  logic [hsid_pkg::hsi_library_addr-1:0] mse_ref,
  input  logic [hsid_pkg::hsi_library_addr-1:0] lib_size,    // Number of references
  output logic [hsid_pkg::hsi_library_addr-1:0] best_ref,    // Index of the closest reference
  output logic [hsid_pkg::word_width-1:0]       best_value,  // Its error
  output logic                                  best_valid   // One pulse per library
);
  import hsid_pkg::*;

  logic [word_width-1:0]       run_value;  // Minimum so far
  logic [hsi_library_addr-1:0] run_ref;
  logic [word_width-1:0]       new_value;  // Minimum including the current error
  logic [hsi_library_addr-1:0] new_ref;
  logic                        take;       // Current error wins
  logic [hsi_library_addr-1:0] final_ref;  // Index closing the library
  logic [hsi_library_addr-1:0] prev_ref;   // Last index seen

  assign final_ref = lib_size - hsi_library_addr'(1);

  // Index zero restarts, otherwise strictly smaller only, so ties keep the lower index
  assign take      = (mse_ref == '0) || (mse_value < run_value);
  assign new_value = take ? mse_value : run_value;
  assign new_ref   = take ? mse_ref : run_ref;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_value  <= '0;
      run_ref    <= '0;
      prev_ref   <= '0;
      best_valid <= 1'b0;
      best_value <= '0;
      best_ref   <= '0;
    end else begin
      best_valid <= mse_valid && (mse_ref == final_ref);
      if (mse_valid) begin
        run_value <= new_value;
        run_ref   <= new_ref;
        prev_ref  <= mse_ref;
        if (mse_ref == final_ref) begin
          best_value <= new_value;  // Presented with the final error included
          best_ref   <= new_ref;
        end
      end
    end
  end

  // Library is scanned in order, each search starting again at index zero
  ref_order_a: assert property (@(posedge clk) disable iff (!rst_n)
    (mse_valid && (mse_ref != '0)) |-> (mse_ref > prev_ref))
    else $error("hsid_min_search: reference %0d out of order", mse_ref);

endmodule

`default_nettype wire

//--- hsid_top.sv
`default_nettype none

module hsid_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  element_valid,  // Element strobe
  input  logic                                  element_start,  // First element of a vector
  input  logic                                  element_last,   // Final element of a vector
  input  logic [hsid_pkg::hsi_library_addr-1:0] vctr_ref,       // Reference index
  input  logic [hsid_pkg::word_width-1:0]       element_a,      // Pixel word
  input  logic [hsid_pkg::word_width-1:0]       element_b,      // Reference word
  input  logic [hsid_pkg::hsi_bands_addr-1:0]   hsi_bands,      // Bands per vector
  input  logic [hsid_pkg::hsi_library_addr-1:0] lib_size,       // References per library
  output logic [hsid_pkg::word_width-1:0]       mse_value,      // Per-reference error
  output logic [hsid_pkg::hsi_library_addr-1:0] mse_ref,
  output logic                                  mse_valid,
  output logic [hsid_pkg::hsi_library_addr-1:0] best_ref,       // Closest reference
  output logic [hsid_pkg::word_width-1:0]       best_value,
  output logic                                  best_valid
);

  hsid_elem_if elem_bus ();  // Element stream into the error unit

  assign elem_bus.element_valid = element_valid;
  assign elem_bus.element_start = element_start;
  assign elem_bus.element_last  = element_last;
  assign elem_bus.vctr_ref      = vctr_ref;
  assign elem_bus.element_a     = element_a;
  assign elem_bus.element_b     = element_b;

  // Per-reference mean square error, 5 cycles after a last element
  hsid_mse u_mse (
    .clk       (clk),
    .rst_n     (rst_n),
    .elem      (elem_bus.sink),
    .hsi_bands (hsi_bands),
    .mse_value (mse_value),
    .mse_ref   (mse_ref),
    .mse_valid (mse_valid)
  );

  // Closest reference, one cycle after the final error
  hsid_min_search u_min_search (
    .clk        (clk),
    .rst_n      (rst_n),
    .mse_valid  (mse_valid),
    .mse_value  (mse_value),
    .mse_ref    (mse_ref),
    .lib_size   (lib_size),
    .best_ref   (best_ref),
    .best_value (best_value),
    .best_valid (best_valid)
  );

endmodule

`default_nettype wire

//--- hsid_tb.sv
`default_nettype none

module hsid_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import hsid_pkg::*;

  localparam int max_refs  = 8;    // Largest library used here
  localparam int max_elems = 32;   // Longest vector used here
  localparam int timeout   = 100;  // Cycles allowed for any output

  logic                        clk;
  logic                        rst_n;
  logic                        element_valid;
  logic                        element_start;
  logic                        element_last;
  logic [hsi_library_addr-1:0] vctr_ref;
  logic [word_width-1:0]       element_a;
  logic [word_width-1:0]       element_b;
  logic [hsi_bands_addr-1:0]   hsi_bands;
  logic [hsi_library_addr-1:0] lib_size;
  logic [word_width-1:0]       mse_value;
  logic [hsi_library_addr-1:0] mse_ref;
  logic                        mse_valid;
  logic [hsi_library_addr-1:0] best_ref;
  logic [word_width-1:0]       best_value;
  logic                        best_valid;

  logic [word_width-1:0] lib_a [max_refs][max_elems];  // Pixel words per reference
  logic [word_width-1:0] lib_b [max_refs][max_elems];  // Reference words
  int                    lib_len [max_refs];           // Elements per vector
  logic [word_width-1:0] exp_mse [max_refs];           // Model errors

  hsid_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("Mismatch at %0t: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, expected));
    end
  endtask

  // Inputs change and outputs are read 2 ns past the edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // Counts edges until mse_valid or best_valid is seen high
  task automatic wait_output(input bit want_best, output int cycles);
    string name;
    name = want_best ? "best_valid" : "mse_valid";
    cycles = 1;
    tick();
    while (!(want_best ? best_valid : mse_valid)) begin
      if (cycles >= timeout) begin
        fail_run($sformatf("%s never arrived within %0d cycles", name, timeout));
      end else begin
        tick();
        cycles++;
      end
    end
  endtask

  task automatic drive_idle();
    element_valid = 1'b0;
    element_start = 1'b0;
    element_last  = 1'b0;
  endtask

  task automatic send_vector(input int idx);
    int e;
    for (e = 0; e < lib_len[idx]; e++) begin
      element_valid = 1'b1;
      element_start = (e == 0);
      element_last  = (e == lib_len[idx] - 1);
      vctr_ref      = hsi_library_addr'(idx);  // Held for the whole vector
      element_a     = lib_a[idx][e];
      element_b     = lib_b[idx][e];
      tick();
    end
  endtask

  // Floor of both lanes' summed squared differences over the band count
  function automatic logic [word_width-1:0] model_mse(input int idx, input int bands);
    longint sum;
    longint d_lo;
    longint d_hi;
    int     e;
    sum = 0;
    for (e = 0; e < lib_len[idx]; e++) begin
      d_lo = longint'(lib_a[idx][e][data_width-1:0])
           - longint'(lib_b[idx][e][data_width-1:0]);
      d_hi = longint'(lib_a[idx][e][word_width-1:data_width])
           - longint'(lib_b[idx][e][word_width-1:data_width]);
      sum  = sum + d_lo * d_lo + d_hi * d_hi;
    end
    return word_width'(sum / longint'(bands));
  endfunction

  task automatic fill_random(input int idx, input int len);
    int e;
    lib_len[idx] = len;
    for (e = 0; e < len; e++) begin
      lib_a[idx][e] = $urandom;
      lib_b[idx][e] = $urandom;
    end
  endtask

  // Streams a whole library with no gaps while results are collected alongside
  task automatic run_library(input int count, input int bands);
    int                          sidx;
    int                          ridx;
    int                          cycles;
    logic [word_width-1:0]       best_v;
    logic [hsi_library_addr-1:0] best_r;
    hsi_bands = hsi_bands_addr'(bands);
    lib_size  = hsi_library_addr'(count);
    best_v    = '0;
    best_r    = '0;
    for (ridx = 0; ridx < count; ridx++) begin
      exp_mse[ridx] = model_mse(ridx, bands);
      if (ridx == 0 || exp_mse[ridx] < best_v) begin  // Strictly smaller so ties keep the lower index
        best_v = exp_mse[ridx];
        best_r = hsi_library_addr'(ridx);
      end
    end
    fork
      begin
        for (sidx = 0; sidx < count; sidx++) send_vector(sidx);
        drive_idle();
      end
      begin
        for (ridx = 0; ridx < count; ridx++) begin
          wait_output(1'b0, cycles);
          check_value("mse_ref", 64'(mse_ref), 64'(ridx));
          check_value("mse_value", 64'(mse_value), 64'(exp_mse[ridx]));
        end
        wait_output(1'b1, cycles);
        check_value("best_valid delay", 64'(cycles), 64'd1);  // One cycle after final error
        check_value("best_ref", 64'(best_ref), 64'(best_r));
        check_value("best_value", 64'(best_value), 64'(best_v));
      end
    join
  endtask

  task automatic test_idle_after_reset();
    int i;
    for (i = 0; i < 10; i++) begin
      tick();
      check_value("mse_valid", 64'(mse_valid), 64'd0);
      check_value("best_valid", 64'(best_valid), 64'd0);
    end
  endtask

  task automatic test_single_vector();
    int e;
    int cycles;
    lib_len[0] = 4;
    for (e = 0; e < 4; e++) begin
      lib_a[0][e] = {16'(1000 + 3 * e), 16'(2000 - e)};
      lib_b[0][e] = {16'(1004 + e), 16'd1990};
    end
    lib_len[1]  = 1;
    lib_a[1][0] = {16'd7, 16'd3};   // Diffs 5 and -7
    lib_b[1][0] = {16'd2, 16'd10};
    lib_size    = 12'd2;
    hsi_bands   = 8'd8;
    send_vector(0);
    drive_idle();
    wait_output(1'b0, cycles);
    check_value("mse_valid delay", 64'(cycles + 1), 64'd5);  // From the last element's own cycle
    check_value("mse_ref", 64'(mse_ref), 64'd0);
    check_value("mse_value", 64'(mse_value), 64'd39);  // 318 over 8 bands
    hsi_bands = 8'd2;
    send_vector(1);
    drive_idle();
    wait_output(1'b0, cycles);
    check_value("mse_valid delay", 64'(cycles + 1), 64'd5);
    check_value("mse_ref", 64'(mse_ref), 64'd1);
    check_value("mse_value", 64'(mse_value), 64'd37);  // 74 over 2 bands
    wait_output(1'b1, cycles);
    check_value("best_valid delay", 64'(cycles), 64'd1);
    check_value("best_ref", 64'(best_ref), 64'd1);
    check_value("best_value", 64'(best_value), 64'd37);
  endtask

  task automatic test_zero_and_extremes();
    int e;
    fill_random(0, 2);
    lib_len[1] = 2;
    for (e = 0; e < 2; e++) begin
      lib_b[0][e] = lib_a[0][e];              // Exact match gives zero
      lib_a[1][e] = {16'hFFFF, 16'h0000};     // Full swing in both lanes
      lib_b[1][e] = {16'h0000, 16'hFFFF};
    end
    run_library(2, 4);
    check_value("best_value", 64'(best_value), 64'd0);
  endtask

  task automatic test_back_to_back();
    int idx;
    for (idx = 0; idx < 6; idx++) fill_random(idx, 1 + (idx * 5) % 4);  // Lengths 1 to 4
    run_library(6, 6);
  endtask

  task automatic test_random_library();
    int idx;
    int n;
    n = 1 + ($urandom % 16);
    for (idx = 0; idx < 8; idx++) fill_random(idx, n);
    run_library(8, 2 * n);  // Two bands per element
  endtask

  task automatic test_tie();
    int                    idx;
    int                    e;
    logic [data_width-1:0] off;
    logic [data_width-1:0] lo;
    logic [data_width-1:0] hi;
    for (idx = 0; idx < 6; idx++) begin
      off = (idx == 2 || idx == 4) ? 16'd1 : 16'(20 + idx);  // Error is off squared
      lib_len[idx] = 5;
      for (e = 0; e < 5; e++) begin
        lo = 16'($urandom % 60000);  // Headroom so the offset never wraps
        hi = 16'($urandom % 60000);
        lib_a[idx][e] = {hi, lo};
        lib_b[idx][e] = {hi + off, lo + off};
      end
    end
    run_library(6, 10);
    check_value("best_ref", 64'(best_ref), 64'd2);
  endtask

  initial begin
    void'($urandom(68705));
    rst_n         = 1'b0;
    element_valid = 1'b0;
    element_start = 1'b0;
    element_last  = 1'b0;
    vctr_ref      = '0;
    element_a     = '0;
    element_b     = '0;
    hsi_bands     = 8'd1;
    lib_size      = 12'd1;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_idle_after_reset();
    test_single_vector();
    test_zero_and_extremes();
    test_back_to_back();
    test_random_library();
    test_tie();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hsid_top.f
hsid_pkg.sv
hsid_elem_if.sv
hsid_acc_if.sv
hsid_sq_df_acc.sv
hsid_mse.sv
hsid_min_search.sv
hsid_top.sv
hsid_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the hsid testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f hsid_top.f --top-module hsid_tb -Mdir obj_dir -o hsid_sim

status=0
./obj_dir/hsid_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation ended without a pass"
  exit 1
fi
echo "Simulation passed"
